//--- sld_pkg.sv
/*
 * vector slide unit definitions
 * element width, slide direction and the control word that travels with each part
 */
package sld_pkg;

    //////////////////////
    // widths

    // largest operand part in bytes, bounds the shift amount field
    localparam int unsigned SLD_MAX_BYTES = 32;
    localparam int unsigned SLD_AMT_W     = $clog2(SLD_MAX_BYTES);

    //////////////////////
    // encodings

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } sld_eew_e;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_dir_e;

    typedef struct packed {
        sld_dir_e dir;
        // move by one element and insert the scalar
        logic     slide1;
        // apply the v0 byte mask
        logic     masked;
    } sld_mode_t;

    //////////////////////
    // control word

    // byte shift view of the scalar word
    typedef struct packed {
        logic [32-SLD_AMT_W-1:0] unused;
        logic [SLD_AMT_W-1:0]    amount;
    } sld_offset_t;

    // slide-1 reads an element value, plain slides read a byte shift
    typedef union packed {
        logic [31:0] scalar;
        sld_offset_t offset;
    } sld_xval_u;

    typedef struct packed {
        sld_mode_t  mode;
        sld_eew_e   eew;
        // no previous part exists
        logic       first_part;
        logic       last_part;
        // index of the last active byte of this part
        logic [4:0] vl_part;
        // no byte of this part is active
        logic       vl_part_0;
        sld_xval_u  xval;
    } sld_ctrl_t;

endpackage

//--- sld_decode.sv
/*
 * slide unit decode stage
 * rewrites the shift, builds the low and high operands and holds the optional operand register
 */
`timescale 1ns/1ps

module sld_decode #(
    parameter int unsigned SLD_OP_W     = 64,
    parameter bit          BUF_OPERANDS = 1'b1
) (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,

    input  logic                    in_valid_i,
    input  sld_pkg::sld_ctrl_t      in_ctrl_i,
    input  logic [SLD_OP_W-1:0]     in_op_i,
    input  logic [SLD_OP_W/8-1:0]   in_mask_i,
    output logic                    in_ready_o,

    input  logic                    res_ready_i,
    output logic                    ex_valid_o,
    output sld_pkg::sld_ctrl_t      ex_ctrl_o,
    output logic [SLD_OP_W-1:0]     low_o,
    output logic [SLD_OP_W-1:0]     high_o,
    output logic                    low_valid_o,
    output logic [SLD_OP_W/8-1:0]   v0_o
);

    localparam int unsigned W    = SLD_OP_W / 8;
    localparam int unsigned SH_W = $clog2(W);

    typedef struct packed {
        sld_pkg::sld_ctrl_t  ctrl;
        logic [SLD_OP_W-1:0] low;
        logic [SLD_OP_W-1:0] high;
        logic                low_valid;
        logic [W-1:0]        v0;
    } op_stage_t;

    op_stage_t           stage_d;
    op_stage_t           stage_q;
    logic                stage_valid_q;
    logic                stage_ready;
    logic [SLD_OP_W-1:0] prev_q;
    logic [SH_W-1:0]     shift;

    //////////////////////
    // shift amount

    always_comb begin
        int unsigned elem_bytes;
        case (in_ctrl_i.eew)
            sld_pkg::EEW_16: elem_bytes = 2;
            sld_pkg::EEW_32: elem_bytes = 4;
            default:         elem_bytes = 1;
        endcase
        if (in_ctrl_i.mode.slide1) begin
            if (in_ctrl_i.mode.dir == sld_pkg::SLD_DOWN) begin
                shift = SH_W'(W - elem_bytes);
            end else begin
                shift = SH_W'(elem_bytes);
            end
        end else begin
            // plain slide, amount modulo the part size
            shift = in_ctrl_i.xval.offset.amount[SH_W-1:0];
        end
    end

    //////////////////////
    // operands

    always_comb begin
        stage_d      = '0;
        stage_d.ctrl = in_ctrl_i;
        stage_d.ctrl.xval.offset.amount            = '0;
        stage_d.ctrl.xval.offset.amount[SH_W-1:0]  = shift;
        stage_d.v0   = in_mask_i;

        stage_d.high = in_op_i;
        if (in_ctrl_i.mode.slide1 && (in_ctrl_i.mode.dir == sld_pkg::SLD_DOWN) &&
            in_ctrl_i.last_part) begin
            stage_d.high[31:0] = in_ctrl_i.xval.scalar;
        end

        // scalar replicated at the element width
        case (in_ctrl_i.eew)
            sld_pkg::EEW_16: begin
                for (int i = 0; i < SLD_OP_W / 16; i++) begin
                    stage_d.low[i*16 +: 16] = in_ctrl_i.xval.scalar[15:0];
                end
            end
            sld_pkg::EEW_32: begin
                for (int i = 0; i < SLD_OP_W / 32; i++) begin
                    stage_d.low[i*32 +: 32] = in_ctrl_i.xval.scalar;
                end
            end
            default: begin
                for (int i = 0; i < W; i++) begin
                    stage_d.low[i*8 +: 8] = in_ctrl_i.xval.scalar[7:0];
                end
            end
        endcase

        // bytes carried over from the previous part
        if (!in_ctrl_i.first_part) begin
            stage_d.low_valid = 1'b1;
            for (int i = 0; i < W; i++) begin
                if (!in_ctrl_i.mode.slide1 || (i <= int'(in_ctrl_i.vl_part))) begin
                    stage_d.low[i*8 +: 8] = prev_q[i*8 +: 8];
                end
            end
        end
    end

    // last accepted part
    always_ff @(posedge clk_i) begin
        if (in_valid_i && stage_ready) begin
            prev_q <= in_op_i;
        end
    end

    //////////////////////
    // operand stage

    if (BUF_OPERANDS) begin : g_op_buf
        always_ff @(posedge clk_i or negedge async_rst_ni) begin
            if (!async_rst_ni) begin
                stage_valid_q <= 1'b0;
            end else if (stage_ready) begin
                stage_valid_q <= in_valid_i;
            end
        end
        always_ff @(posedge clk_i) begin
            if (stage_ready && in_valid_i) begin
                stage_q <= stage_d;
            end
        end
        assign stage_ready = ~stage_valid_q | res_ready_i;
    end else begin : g_op_pass
        assign stage_valid_q = in_valid_i;
        assign stage_q       = stage_d;
        assign stage_ready   = res_ready_i;
    end

    assign in_ready_o  = stage_ready;
    assign ex_valid_o  = stage_valid_q;
    assign ex_ctrl_o   = stage_q.ctrl;
    assign low_o       = stage_q.low;
    assign high_o      = stage_q.high;
    assign low_valid_o = stage_q.low_valid;
    assign v0_o        = stage_q.v0;

endmodule

//--- sld_execute.sv
/*
 * slide unit byte shifter
 * selects each result byte from the low/high operand window and marks valid sources
 */
`timescale 1ns/1ps

module sld_execute #(
    parameter int unsigned SLD_OP_W = 64
) (
    input  sld_pkg::sld_ctrl_t    ctrl_i,
    input  logic [SLD_OP_W-1:0]   low_i,
    input  logic [SLD_OP_W-1:0]   high_i,
    input  logic                  low_valid_i,
    output logic [SLD_OP_W-1:0]   res_o,
    output logic [SLD_OP_W/8-1:0] src_mask_o
);

    localparam int unsigned W    = SLD_OP_W / 8;
    localparam int unsigned SH_W = $clog2(W);

    // low operand in the lower half, high operand in the upper half
    logic [2*SLD_OP_W-1:0] window;
    logic [SH_W-1:0]       shift;
    logic                  slide1;

    assign window = {high_i, low_i};
    assign shift  = ctrl_i.xval.offset.amount[SH_W-1:0];
    assign slide1 = ctrl_i.mode.slide1;

    //////////////////////
    // funnel shift

    always_comb begin
        res_o      = '0;
        src_mask_o = '0;
        for (int i = 0; i < W; i++) begin
            if (i >= int'(shift)) begin
                // byte comes from the high operand
                res_o[i*8 +: 8] = window[(W + i - int'(shift))*8 +: 8];
                src_mask_o[i]   = 1'b1;
            end else if (low_valid_i || slide1) begin
                res_o[i*8 +: 8] = window[(W + i - int'(shift))*8 +: 8];
                src_mask_o[i]   = low_valid_i;
            end
            // otherwise there is no previous part and the byte stays zero
        end

        // slide-1 always fills every byte, either from data or from the scalar
        if (slide1) begin
            src_mask_o = '1;
        end
    end

endmodule

//--- sld_result.sv
/*
 * slide unit result stage
 * holds the optional result register and forms the final byte write mask
 */
`timescale 1ns/1ps

module sld_result #(
    parameter int unsigned SLD_OP_W    = 64,
    parameter bit          BUF_RESULTS = 1'b1
) (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,

    input  logic                    ex_valid_i,
    input  sld_pkg::sld_ctrl_t      ctrl_i,
    input  logic [SLD_OP_W-1:0]     res_i,
    input  logic [SLD_OP_W/8-1:0]   src_mask_i,
    input  logic [SLD_OP_W/8-1:0]   v0_i,
    output logic                    res_ready_o,

    input  logic                    out_ready_i,
    output logic                    out_valid_o,
    output sld_pkg::sld_ctrl_t      out_ctrl_o,
    output logic [SLD_OP_W-1:0]     out_res_o,
    output logic [SLD_OP_W/8-1:0]   out_mask_o
);

    localparam int unsigned W = SLD_OP_W / 8;

    typedef struct packed {
        sld_pkg::sld_ctrl_t  ctrl;
        logic [SLD_OP_W-1:0] res;
        logic [W-1:0]        src_mask;
        logic [W-1:0]        v0;
    } res_stage_t;

    res_stage_t   stage_d;
    res_stage_t   stage_q;
    logic         stage_valid_q;
    logic         stage_ready;
    logic [W-1:0] vl_mask;
    logic [W-1:0] v0_mask;

    assign stage_d = '{ctrl: ctrl_i, res: res_i, src_mask: src_mask_i, v0: v0_i};

    //////////////////////
    // result stage

    if (BUF_RESULTS) begin : g_res_buf
        always_ff @(posedge clk_i or negedge async_rst_ni) begin
            if (!async_rst_ni) begin
                stage_valid_q <= 1'b0;
            end else if (stage_ready) begin
                stage_valid_q <= ex_valid_i;
            end
        end
        always_ff @(posedge clk_i) begin
            if (stage_ready && ex_valid_i) begin
                stage_q <= stage_d;
            end
        end
        assign stage_ready = ~stage_valid_q | out_ready_i;
    end else begin : g_res_pass
        assign stage_valid_q = ex_valid_i;
        assign stage_q       = stage_d;
        assign stage_ready   = out_ready_i;
    end

    //////////////////////
    // write mask

    // bytes 0 up to vl_part are active
    always_comb begin
        vl_mask = '0;
        for (int i = 0; i < W; i++) begin
            vl_mask[i] = !stage_q.ctrl.vl_part_0 && (i <= int'(stage_q.ctrl.vl_part));
        end
    end

    assign v0_mask = stage_q.ctrl.mode.masked ? stage_q.v0 : '1;

    assign res_ready_o = stage_ready;
    assign out_valid_o = stage_valid_q;
    assign out_ctrl_o  = stage_q.ctrl;
    assign out_res_o   = stage_q.res;
    assign out_mask_o  = stage_q.src_mask & v0_mask & vl_mask;

endmodule

//--- sld_unit.sv
/*
 * streaming vector slide unit
 * decode, byte shifter and result stage in a valid/ready pipeline
 */
`timescale 1ns/1ps

module sld_unit #(
    parameter int unsigned SLD_OP_W     = 64,
    parameter bit          BUF_OPERANDS = 1'b1,
    parameter bit          BUF_RESULTS  = 1'b1
) (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,

    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  sld_pkg::sld_ctrl_t      in_ctrl_i,
    input  logic [SLD_OP_W-1:0]     in_op_i,
    input  logic [SLD_OP_W/8-1:0]   in_mask_i,

    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output sld_pkg::sld_ctrl_t      out_ctrl_o,
    output logic [SLD_OP_W-1:0]     out_res_o,
    output logic [SLD_OP_W/8-1:0]   out_mask_o
);

    // decode to execute
    logic                  ex_valid;
    sld_pkg::sld_ctrl_t    ex_ctrl;
    logic [SLD_OP_W-1:0]   low;
    logic [SLD_OP_W-1:0]   high;
    logic                  low_valid;
    logic [SLD_OP_W/8-1:0] v0;

    // execute to result
    logic [SLD_OP_W-1:0]   res;
    logic [SLD_OP_W/8-1:0] src_mask;
    logic                  res_ready;

    sld_decode #(
        .SLD_OP_W     (SLD_OP_W),
        .BUF_OPERANDS (BUF_OPERANDS)
    ) sld_decode_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ctrl_i    (in_ctrl_i),
        .in_op_i      (in_op_i),
        .in_mask_i    (in_mask_i),
        .in_ready_o   (in_ready_o),
        .res_ready_i  (res_ready),
        .ex_valid_o   (ex_valid),
        .ex_ctrl_o    (ex_ctrl),
        .low_o        (low),
        .high_o       (high),
        .low_valid_o  (low_valid),
        .v0_o         (v0)
    );

    sld_execute #(
        .SLD_OP_W (SLD_OP_W)
    ) sld_execute_i (
        .ctrl_i      (ex_ctrl),
        .low_i       (low),
        .high_i      (high),
        .low_valid_i (low_valid),
        .res_o       (res),
        .src_mask_o  (src_mask)
    );

    sld_result #(
        .SLD_OP_W    (SLD_OP_W),
        .BUF_RESULTS (BUF_RESULTS)
    ) sld_result_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .ex_valid_i   (ex_valid),
        .ctrl_i       (ex_ctrl),
        .res_i        (res),
        .src_mask_i   (src_mask),
        .v0_i         (v0),
        .res_ready_o  (res_ready),
        .out_ready_i  (out_ready_i),
        .out_valid_o  (out_valid_o),
        .out_ctrl_o   (out_ctrl_o),
        .out_res_o    (out_res_o),
        .out_mask_o   (out_mask_o)
    );

endmodule

//--- sld_tb_model.svh
/*
 * slide unit reference model
 * predicts the control word, result and write mask of each part, with typed compares
 */
`ifndef SLD_TB_MODEL_SVH
`define SLD_TB_MODEL_SVH

typedef struct packed {
    sld_pkg::sld_ctrl_t ctrl;
    logic [OP_W-1:0]    res;
    logic [W-1:0]       mask;
} expect_t;

expect_t         exp_q[$];
// last part accepted by the unit
logic [OP_W-1:0] model_prev;
int              test_errors;
int              total_errors;

//////////////////////
// model

function automatic expect_t predict_part(input sld_pkg::sld_ctrl_t c,
                                         input logic [OP_W-1:0] op,
                                         input logic [W-1:0] v0);
    expect_t           e;
    logic [OP_W-1:0]   low;
    logic [OP_W-1:0]   high;
    logic [2*OP_W-1:0] win;
    logic              low_valid;
    logic [W-1:0]      src;
    logic [W-1:0]      vl;
    int                eb;
    int                s;
    eb = 1 << c.eew;
    if (!c.mode.slide1) begin
        s = c.xval.offset.amount % W;
    end else if (c.mode.dir == sld_pkg::SLD_DOWN) begin
        s = W - eb;
    end else begin
        s = eb;
    end

    high = op;
    if (c.mode.slide1 && c.mode.dir == sld_pkg::SLD_DOWN && c.last_part) begin
        high[31:0] = c.xval.scalar;
    end
    low_valid = !c.first_part;
    for (int i = 0; i < W; i++) begin
        low[i*8 +: 8] = c.xval.scalar[(i % eb)*8 +: 8];
        if (low_valid && (!c.mode.slide1 || i <= c.vl_part)) begin
            low[i*8 +: 8] = model_prev[i*8 +: 8];
        end
    end

    // window is low operand then high operand
    win = {high, low};
    for (int i = 0; i < W; i++) begin
        e.res[i*8 +: 8] = win[(W + i - s)*8 +: 8];
        src[i] = (i >= s) || low_valid || c.mode.slide1;
        vl[i]  = !c.vl_part_0 && (i <= c.vl_part);
    end
    e.mask = src & (c.mode.masked ? v0 : {W{1'b1}}) & vl;
    e.ctrl = c;
    e.ctrl.xval.offset.amount = s[4:0];
    model_prev = op;
    return e;
endfunction

//////////////////////
// compares

task automatic note_error();
    test_errors++;
    total_errors++;
endtask

task automatic compare_ctrl(input string name, input sld_pkg::sld_ctrl_t exp,
                            input sld_pkg::sld_ctrl_t act);
    if (act !== exp) begin
        $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        note_error();
    end
endtask

task automatic compare_res(input string name, input logic [OP_W-1:0] exp,
                           input logic [OP_W-1:0] act, input logic [W-1:0] byte_en);
    logic [OP_W-1:0] keep;
    for (int i = 0; i < W; i++) begin
        keep[i*8 +: 8] = {8{byte_en[i]}};
    end
    if ((act & keep) !== (exp & keep)) begin
        $display("error at %0t ns: %s expected %h, got %h (bytes %b)",
                 $time, name, exp, act, byte_en);
        note_error();
    end
endtask

task automatic compare_mask(input string name, input logic [W-1:0] exp,
                            input logic [W-1:0] act);
    if (act !== exp) begin
        $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        note_error();
    end
endtask

`endif

//--- sld_tb.sv
/*
 * testbench for the streaming vector slide unit
 * random vectors with back-pressure checked against a byte-level model
 */
`timescale 1ns/1ps

module sld_tb;

    localparam int OP_W       = 64;
    localparam int W          = OP_W / 8;
    localparam int CLK_HALF   = 20;
    localparam int N_VEC      = 24;
    // five random tests of up to 4 parts per vector, plus the latency part
    localparam int MAX_PARTS  = 5 * N_VEC * 4 + 1;
    localparam int WATCHDOG_NS = (MAX_PARTS + 16) * 8 * 2 * CLK_HALF;

    logic               clk_i = 1'b0;
    logic               async_rst_ni;
    logic               in_valid_i;
    logic               in_ready_o;
    sld_pkg::sld_ctrl_t in_ctrl_i;
    logic [OP_W-1:0]    in_op_i;
    logic [W-1:0]       in_mask_i;
    logic               out_valid_o;
    logic               out_ready_i;
    sld_pkg::sld_ctrl_t out_ctrl_o;
    logic [OP_W-1:0]    out_res_o;
    logic [W-1:0]       out_mask_o;

    int      seed;
    logic    bp_enable;
    int      parts_sent;
    int      tests_passed;
    int      tests_failed;
    logic    stalled;

    `include "sld_tb_model.svh"

    // output seen at the last stalled edge
    expect_t held;

    sld_unit #(
        .SLD_OP_W (OP_W)
    ) sld_unit_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_ctrl_i    (in_ctrl_i),
        .in_op_i      (in_op_i),
        .in_mask_i    (in_mask_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_ctrl_o   (out_ctrl_o),
        .out_res_o    (out_res_o),
        .out_mask_o   (out_mask_o)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    //////////////////////
    // output monitor

    always @(posedge clk_i) begin
        expect_t e;
        if (!async_rst_ni) begin
            stalled = 1'b0;
        end else begin
            if (stalled && (!out_valid_o || out_ctrl_o !== held.ctrl ||
                            out_res_o !== held.res || out_mask_o !== held.mask)) begin
                flag_failure("output changed while the unit was stalled");
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    flag_failure("output transfer without a matching input part");
                end else begin
                    e = exp_q.pop_front();
                    compare_ctrl("out_ctrl_o", e.ctrl, out_ctrl_o);
                    compare_mask("out_mask_o", e.mask, out_mask_o);
                    compare_res("out_res_o", e.res, out_res_o, e.mask);
                end
            end
            stalled = out_valid_o && !out_ready_i;
            held    = '{ctrl: out_ctrl_o, res: out_res_o, mask: out_mask_o};
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: the run stalled with %0d results still queued", exp_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    //////////////////////
    // stimulus

    task automatic flag_failure(input string msg);
        $display("failure at %0t ns: %s", $time, msg);
        note_error();
    endtask

    task automatic drive_ready();
        out_ready_i = !bp_enable || ($random(seed) % 2 != 0);
    endtask

    task automatic apply_reset();
        async_rst_ni = 1'b0;
        repeat (5) @(negedge clk_i);
        async_rst_ni = 1'b1;
    endtask

    // starts and ends right after a falling edge
    task automatic send_part(input sld_pkg::sld_ctrl_t ctrl, input logic [OP_W-1:0] op,
                             input logic [W-1:0] v0);
        while (bp_enable && ($random(seed) % 3 == 0)) begin
            in_valid_i = 1'b0;
            @(negedge clk_i);
            drive_ready();
        end
        in_valid_i = 1'b1;
        in_ctrl_i  = ctrl;
        in_op_i    = op;
        in_mask_i  = v0;
        @(posedge clk_i);
        while (!in_ready_o) begin
            @(negedge clk_i);
            drive_ready();
            @(posedge clk_i);
        end
        exp_q.push_back(predict_part(ctrl, op, v0));
        parts_sent++;
        @(negedge clk_i);
        drive_ready();
        in_valid_i = 1'b0;
    endtask

    task automatic send_vector(input int kind, input int eew_sel);
        sld_pkg::sld_ctrl_t ctrl;
        logic [OP_W-1:0]    op;
        logic [W-1:0]       v0;
        int                 n_parts;
        ctrl             = '0;
        n_parts          = 1 + {$random(seed)} % 4;
        ctrl.eew         = sld_pkg::sld_eew_e'(eew_sel);
        ctrl.mode.dir    = sld_pkg::sld_dir_e'($random(seed) % 2 != 0);
        ctrl.xval.scalar = $random(seed);
        case (kind)
            1: ctrl.mode.slide1 = 1'b0;
            2: begin
                ctrl.mode.slide1 = 1'b1;
                ctrl.mode.dir    = sld_pkg::SLD_UP;
            end
            3: begin
                ctrl.mode.slide1 = 1'b1;
                ctrl.mode.dir    = sld_pkg::SLD_DOWN;
            end
            default: begin
                ctrl.mode.slide1 = ($random(seed) % 2 != 0);
                ctrl.mode.masked = (kind == 4) || ($random(seed) % 2 != 0);
            end
        endcase
        for (int p = 0; p < n_parts; p++) begin
            ctrl.first_part = (p == 0);
            ctrl.last_part  = (p == n_parts - 1);
            ctrl.vl_part    = 5'(W - 1);
            ctrl.vl_part_0  = 1'b0;
            if (kind >= 4) begin
                ctrl.vl_part   = 5'({$random(seed)} % W);
                ctrl.vl_part_0 = ({$random(seed)} % 8 == 0);
            end
            op = {$random(seed), $random(seed)};
            v0 = W'($random(seed));
            send_part(ctrl, op, v0);
        end
    endtask

    task automatic drain_outputs();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
            drive_ready();
        end
        @(negedge clk_i);
    endtask

    task automatic finish_test(input int id, input string title);
        $display("test %0d (%s): %0d parts, %0d errors, %s", id, title, parts_sent,
                 test_errors, (test_errors == 0) ? "passed" : "failed");
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        test_errors = 0;
        parts_sent  = 0;
    endtask

    task automatic run_test(input int kind, input string title);
        bp_enable = (kind == 5);
        for (int v = 0; v < N_VEC; v++) begin
            send_vector(kind, v % 3);
        end
        drain_outputs();
        bp_enable   = 1'b0;
        out_ready_i = 1'b1;
        finish_test(kind, title);
    endtask

    // idle unit after reset, then one part through an empty pipeline
    task automatic run_reset_test();
        sld_pkg::sld_ctrl_t ctrl;
        int                 n;
        apply_reset();
        if (out_valid_o !== 1'b0) begin
            flag_failure("out_valid_o is not low right after reset");
        end
        if (in_ready_o !== 1'b1) begin
            flag_failure("in_ready_o is not high right after reset");
        end
        repeat (3) @(negedge clk_i);
        ctrl             = '0;
        ctrl.first_part  = 1'b1;
        ctrl.last_part   = 1'b1;
        ctrl.vl_part     = 5'(W - 1);
        ctrl.xval.scalar = $random(seed);
        send_part(ctrl, {$random(seed), $random(seed)}, W'($random(seed)));
        n = 0;
        while (n < 8) begin
            @(posedge clk_i);
            n++;
            if (out_valid_o) begin
                break;
            end
        end
        if (n != 2) begin
            flag_failure($sformatf("first result came %0d cycles after its input, not 2", n));
        end
        drain_outputs();
        finish_test(6, "reset and latency");
    endtask

    initial begin
        seed         = 32'h7122;
        in_valid_i   = 1'b0;
        in_ctrl_i    = '0;
        in_op_i      = '0;
        in_mask_i    = '0;
        out_ready_i  = 1'b1;
        bp_enable    = 1'b0;
        stalled      = 1'b0;
        model_prev   = '0;
        test_errors  = 0;
        total_errors = 0;
        parts_sent   = 0;
        tests_passed = 0;
        tests_failed = 0;
        apply_reset();

        run_test(1, "plain slides");
        run_test(2, "slide-1-up");
        run_test(3, "slide-1-down");
        run_test(4, "masked with vector length");
        run_test(5, "random back-pressure");
        run_reset_test();

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
sld_pkg.sv
sld_decode.sv
sld_execute.sv
sld_result.sv
sld_unit.sv
sld_tb.sv
